//--- icache.f
icache_pkg.sv
icache_ram_if.sv
icache_scr_ram.sv
icache_key_ctrl.sv
icache_lookup.sv
icache_refill.sv
icache_top.sv
icache_assertions.sv
icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := icache_tb
FILELIST  := icache.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert --Mdir $(OBJDIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- icache_tb.sv
/*
 * Instruction cache testbench
 * Memory and key provider models, reference cache model and response checker
 */

`timescale 1ns/1ps

module icache_tb;

  localparam int NUM_LINES = 16;
  localparam int IDX_W     = $clog2(NUM_LINES);
  localparam int TIMEOUT   = 200;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        err;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        fetch_req_i;
  logic [31:0] fetch_addr_i;
  logic        inval_i;
  logic        fetch_valid_o;
  logic [31:0] fetch_rdata_o;
  logic        fetch_err_o;
  logic [31:0] fetch_addr_o;
  logic        busy_o;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic        mem_gnt_i;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic        mem_err_i;
  logic        key_req_o;
  logic        key_valid_i;
  logic [63:0] key_i;

  logic [31:0] lcg_q = 32'd37;
  logic        ref_valid [NUM_LINES];
  logic [31:0] ref_tag   [NUM_LINES];
  expect_t     exp_q [$];
  int          mem_reqs;
  logic [31:0] last_mem_addr;
  string       test_name;

  icache_top #(.NumLines(NUM_LINES)) dut_i (.*);

  bind icache_top icache_assertions assertions_i (
    .clk(clk), .rst_n(rst_n), .fetch_req_i(fetch_req_i), .busy_o(busy_o),
    .fetch_valid_o(fetch_valid_o), .fetch_addr_o(fetch_addr_o),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_gnt_i(mem_gnt_i),
    .key_req_o(key_req_o), .key_valid_i(key_valid_i)
  );

  function automatic logic [31:0] next_rand();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return lcg_q;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return (next_rand() >> 16) % n;
  endfunction

  // Memory content is a fixed mix of the address bits
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ 32'h9e37_79b9;
  endfunction

  function automatic logic in_err_region(input logic [31:0] addr);
    return addr[31:28] == 4'hf;
  endfunction

  // Reference cache, predicts one fetch and updates its own lines
  function automatic void predict_fetch(input logic [31:0] addr, output expect_t want,
                                        output logic miss);
    logic [IDX_W-1:0] idx;
    logic [31:0]      tag;
    idx       = addr[IDX_W+1:2];
    tag       = addr >> (IDX_W + 2);
    miss      = !(ref_valid[idx] && ref_tag[idx] == tag);
    want.addr = addr;
    want.data = mem_word(addr);
    want.err  = in_err_region(addr);
    // Error fills leave the old line untouched
    if (miss && !want.err) begin
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
    end
  endfunction

  function automatic void clear_model();
    for (int i = 0; i < NUM_LINES; i++) begin
      ref_valid[i] = 1'b0;
      ref_tag[i]   = '0;
    end
  endfunction

  function automatic string mismatch_line(input string what,
                                          input logic [31:0] expected, actual);
    return $sformatf("Mismatch in %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
  endfunction

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Memory grants and answers after 0 to 3 extra cycles each
  initial begin : memory_model
    int unsigned wait_cnt;
    int          phase;
    logic [31:0] addr;
    logic        gnt_n;
    logic        rvalid_n;
    mem_gnt_i     = 1'b0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    mem_err_i     = 1'b0;
    mem_reqs      = 0;
    last_mem_addr = '0;
    phase         = 0;
    wait_cnt      = 0;
    addr          = '0;
    forever begin
      @(negedge clk);
      gnt_n    = 1'b0;
      rvalid_n = 1'b0;
      if (phase == 0 && mem_req_o) begin
        mem_reqs++;
        addr          = mem_addr_o;
        last_mem_addr = mem_addr_o;
        wait_cnt      = rand_below(4);
        phase         = 1;
      end
      if (phase == 1) begin
        if (wait_cnt == 0) begin
          gnt_n    = 1'b1;
          wait_cnt = rand_below(4);
          phase    = 2;
        end else begin
          wait_cnt--;
        end
      end else if (phase == 2) begin
        if (wait_cnt == 0) begin
          rvalid_n = 1'b1;
          phase    = 0;
        end else begin
          wait_cnt--;
        end
      end
      @(posedge clk);
      #2;
      mem_gnt_i    = gnt_n;
      mem_rvalid_i = rvalid_n;
      mem_rdata_i  = rvalid_n ? mem_word(addr) : '0;
      mem_err_i    = rvalid_n && in_err_region(addr);
    end
  end

  // Key provider answers 1 to 4 cycles after the request
  initial begin : key_provider
    int unsigned wait_cnt;
    logic        pending;
    logic        valid_n;
    key_valid_i = 1'b0;
    key_i       = '0;
    pending     = 1'b0;
    wait_cnt    = 0;
    forever begin
      @(negedge clk);
      valid_n = 1'b0;
      if (!pending && key_req_o && !key_valid_i) begin
        pending  = 1'b1;
        wait_cnt = rand_below(4);
      end
      if (pending) begin
        if (wait_cnt == 0) begin
          valid_n = 1'b1;
          pending = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      @(posedge clk);
      #2;
      key_valid_i = valid_n;
      if (valid_n) begin
        key_i = {next_rand(), next_rand()};
      end
    end
  end

  initial begin : response_checker
    expect_t want;
    forever begin
      @(negedge clk);
      if (rst_n && fetch_valid_o) begin
        assert (exp_q.size() > 0)
          else report_fail("fetch_valid_o pulsed with no fetch outstanding");
        want = exp_q.pop_front();
        assert (fetch_addr_o == want.addr)
          else report_fail(mismatch_line("fetch_addr_o", want.addr, fetch_addr_o));
        assert (fetch_rdata_o == want.data)
          else report_fail(mismatch_line("fetch_rdata_o", want.data, fetch_rdata_o));
        assert (fetch_err_o == want.err)
          else report_fail(mismatch_line("fetch_err_o", 32'(want.err), 32'(fetch_err_o)));
      end
    end
  end

  task automatic run_fetch(input logic [31:0] addr);
    expect_t want;
    logic    miss;
    logic    seen;
    int      reqs0;
    int      cycles;
    predict_fetch(addr, want, miss);
    reqs0        = mem_reqs;
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    cycles       = 0;
    @(negedge clk);
    while (busy_o) begin
      cycles++;
      assert (cycles < TIMEOUT) else report_fail("fetch never accepted, busy_o stuck high");
      @(negedge clk);
    end
    exp_q.push_back(want);
    // Accepting edge
    @(posedge clk);
    #2;
    // A second strobe while busy must be ignored
    fetch_addr_i = addr ^ 32'h0000_0100;
    cycles       = 0;
    seen         = 1'b0;
    while (!seen) begin
      @(posedge clk);
      cycles++;
      #2;
      fetch_req_i = 1'b0;
      @(negedge clk);
      seen = fetch_valid_o;
      assert (seen || cycles < TIMEOUT) else report_fail("no response to an accepted fetch");
    end
    @(posedge clk);
    #2;
    assert (mem_reqs - reqs0 == (miss ? 1 : 0))
      else report_fail(mismatch_line("memory requests", miss ? 1 : 0, mem_reqs - reqs0));
    if (miss) begin
      assert (last_mem_addr == addr)
        else report_fail(mismatch_line("mem_addr_o", addr, last_mem_addr));
    end else begin
      assert (cycles == 2) else report_fail(mismatch_line("hit latency", 2, cycles));
    end
  endtask

  task automatic run_invalidate();
    int cycles;
    inval_i = 1'b1;
    @(posedge clk);
    #2;
    inval_i = 1'b0;
    clear_model();
    @(negedge clk);
    assert (key_req_o) else report_fail("key_req_o did not rise after the invalidate");
    cycles = 0;
    while (busy_o) begin
      cycles++;
      assert (cycles < TIMEOUT) else report_fail("busy_o stuck high after the invalidate");
      @(negedge clk);
    end
    assert (!key_req_o) else report_fail("busy_o dropped while the new key was pending");
    assert (cycles >= NUM_LINES) else report_fail("busy_o dropped before the valid sweep ended");
    @(posedge clk);
    #2;
  endtask

  initial begin : stimulus
    int unsigned pick;
    rst_n        = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    inval_i      = 1'b0;
    test_name    = "reset";
    clear_model();
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    assert (!busy_o && !key_req_o) else report_fail("cache busy or requesting a key after reset");

    test_name = "cold_miss";
    for (int i = 0; i < 8; i++) run_fetch(32'h0000_1000 + 32'(4 * i));
    test_name = "hit";
    for (int i = 0; i < 8; i++) run_fetch(32'h0000_1000 + 32'(4 * i));
    // Same index, different tags
    test_name = "conflict";
    for (int i = 0; i < 4; i++) begin
      run_fetch(32'h0000_2040);
      run_fetch(32'h0000_6040);
    end
    test_name = "error";
    run_fetch(32'hf000_0010);
    run_fetch(32'hf000_0010);
    run_fetch(32'h0000_1010);
    test_name = "rekey";
    run_invalidate();
    for (int i = 0; i < 8; i++) run_fetch(32'h0000_1000 + 32'(4 * i));

    // 64 words over 16 lines, the top eight in the error region
    test_name = "random";
    for (int n = 0; n < 300; n++) begin
      if (rand_below(40) == 0) begin
        run_invalidate();
      end
      pick = rand_below(64);
      run_fetch((pick >= 56 ? 32'hf000_3000 : 32'h0000_3000) + (pick << 2));
    end

    repeat (4) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_fail("fetches still unanswered at the end of the run");
    end
  end

endmodule

//--- icache_assertions.sv
/*
 * Cache protocol assertions
 * Memory, key and core port rules, bound into the cache top level
 */

`timescale 1ns/1ps

module icache_assertions (
  input logic                          clk,
  input logic                          rst_n,
  input logic                          fetch_req_i,
  input logic                          busy_o,
  input logic                          fetch_valid_o,
  input logic [icache_pkg::ADDR_W-1:0] fetch_addr_o,
  input logic                          mem_req_o,
  input logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
  input logic                          mem_gnt_i,
  input logic                          key_req_o,
  input logic                          key_valid_i
);

  // Memory request level and address held until granted
  mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
    else $error("mem_req_o dropped or mem_addr_o changed before the grant");

  // Key request level held until the key arrives
  key_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    key_req_o && !key_valid_i |=> key_req_o)
    else $error("key_req_o dropped before key_valid_i");

  // Response is a single-cycle pulse
  valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_valid_o |=> !fetch_valid_o)
    else $error("fetch_valid_o high for two cycles in a row");

  // The latched fetch address only moves on an accepted fetch
  no_busy_accept: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_req_i && busy_o |=> $stable(fetch_addr_o))
    else $error("a fetch was accepted while busy_o was high");

endmodule

//--- icache_top.sv
/*
 * Scrambled direct-mapped instruction cache
 * Lookup, refill, key control and two scrambled RAMs
 */

`timescale 1ns/1ps

module icache_top #(
  parameter int                           NumLines = icache_pkg::DEFAULT_LINES,
  parameter logic [icache_pkg::KEY_W-1:0] KeyInit  = 64'h5a3c_96e1_0f87_d24b
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // Core side
  input  logic                          fetch_req_i,
  input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                          inval_i,
  output logic                          fetch_valid_o,
  output logic [icache_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic                          fetch_err_o,
  output logic [icache_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic                          busy_o,
  // Memory side
  output logic                          mem_req_o,
  output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  logic [icache_pkg::DATA_W-1:0] mem_rdata_i,
  input  logic                          mem_err_i,
  // Key provider
  output logic                          key_req_o,
  input  logic                          key_valid_i,
  input  logic [icache_pkg::KEY_W-1:0]  key_i
);

  localparam int IdxW = $clog2(NumLines);

  logic [icache_pkg::KEY_W-1:0]  key;
  logic                          key_ready;
  logic                          miss;
  logic [icache_pkg::ADDR_W-1:0] miss_addr;
  logic                          fill_done;
  logic                          fill_write;
  logic [icache_pkg::DATA_W-1:0] fill_data;
  logic                          fill_err;
  icache_pkg::tag_entry_t        wr_tag;
  logic [IdxW-1:0]               wr_idx;

  icache_ram_if #(.IdxW(IdxW), .payload_t(icache_pkg::tag_entry_t)) tag_ram_if ();
  icache_ram_if #(.IdxW(IdxW), .payload_t(logic [icache_pkg::DATA_W-1:0])) data_ram_if ();

  icache_key_ctrl #(.KeyInit(KeyInit)) key_ctrl_i (
    .clk, .rst_n, .inval_i, .key_valid_i, .key_i, .key_req_o,
    .key_o      (key),
    .key_ready_o(key_ready)
  );

  icache_lookup #(.NumLines(NumLines), .IdxW(IdxW)) lookup_i (
    .clk, .rst_n, .fetch_req_i, .fetch_addr_i, .inval_i,
    .key_ready_i(key_ready),
    .fetch_valid_o, .fetch_rdata_o, .fetch_err_o, .fetch_addr_o, .busy_o,
    .tag_ram    (tag_ram_if),
    .data_ram   (data_ram_if),
    .miss_o     (miss),
    .miss_addr_o(miss_addr),
    .fill_done_i(fill_done),
    .fill_write_i(fill_write),
    .fill_data_i(fill_data),
    .fill_err_i (fill_err),
    .fill_idx_i (wr_idx),
    .fill_tag_i (wr_tag)
  );

  icache_refill #(.IdxW(IdxW)) refill_i (
    .clk, .rst_n,
    .miss_i     (miss),
    .miss_addr_i(miss_addr),
    .mem_req_o, .mem_addr_o, .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i, .mem_err_i,
    .fill_done_o(fill_done),
    .fill_write_o(fill_write),
    .fill_data_o(fill_data),
    .fill_err_o (fill_err),
    .wr_tag_o   (wr_tag),
    .wr_idx_o   (wr_idx)
  );

  icache_scr_ram #(.Depth(NumLines), .payload_t(icache_pkg::tag_entry_t)) tag_ram_i (
    .clk, .rst_n, .key_i(key), .ram(tag_ram_if)
  );

  icache_scr_ram #(.Depth(NumLines), .payload_t(logic [icache_pkg::DATA_W-1:0])) data_ram_i (
    .clk, .rst_n, .key_i(key), .ram(data_ram_if)
  );

endmodule

//--- icache_refill.sv
/*
 * Cache refill
 * Fetches a missing word over the memory port and writes it back
 */

`timescale 1ns/1ps

module icache_refill #(
  parameter int IdxW = icache_pkg::DEFAULT_IDX_W
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          miss_i,
  input  logic [icache_pkg::ADDR_W-1:0] miss_addr_i,
  output logic                          mem_req_o,
  output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
  input  logic                          mem_gnt_i,
  input  logic                          mem_rvalid_i,
  input  logic [icache_pkg::DATA_W-1:0] mem_rdata_i,
  input  logic                          mem_err_i,
  output logic                          fill_done_o,
  output logic                          fill_write_o,
  output logic [icache_pkg::DATA_W-1:0] fill_data_o,
  output logic                          fill_err_o,
  output icache_pkg::tag_entry_t        wr_tag_o,
  output logic [IdxW-1:0]               wr_idx_o
);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQ,
    RF_RESP
  } rf_state_e;

  rf_state_e                     state_q;
  logic [icache_pkg::ADDR_W-1:0] addr_q;
  logic [icache_pkg::ADDR_W-1:0] tag_bits;
  logic                          resp_phase;

  // A response may also land in the grant cycle itself
  assign resp_phase = (state_q == RF_RESP) || (state_q == RF_REQ && mem_gnt_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RF_IDLE;
    end else begin
      case (state_q)
        RF_IDLE: if (miss_i) state_q <= RF_REQ;
        RF_REQ: begin
          if (mem_gnt_i) begin
            state_q <= mem_rvalid_i ? RF_IDLE : RF_RESP;
          end
        end
        RF_RESP: if (mem_rvalid_i) state_q <= RF_IDLE;
        default: state_q <= RF_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE && miss_i) begin
      addr_q <= miss_addr_i;
    end
  end

  // Request and word-aligned address are held until the grant
  assign mem_req_o  = (state_q == RF_REQ);
  assign mem_addr_o = {addr_q[icache_pkg::ADDR_W-1:2], 2'b00};

  assign fill_done_o  = resp_phase && mem_rvalid_i;
  assign fill_write_o = fill_done_o && !mem_err_i;
  assign fill_data_o  = mem_rdata_i;
  assign fill_err_o   = mem_err_i;

  assign tag_bits     = addr_q >> (IdxW + 2);
  assign wr_tag_o.tag = tag_bits[icache_pkg::TAG_W-1:0];
  assign wr_idx_o     = addr_q[IdxW+1:2];

endmodule

//--- icache_lookup.sv
/*
 * Cache lookup
 * Accepts fetches, reads tag and data RAMs, resolves hit or miss,
 * owns the valid bits and sweeps them clear on invalidate
 */

`timescale 1ns/1ps

module icache_lookup #(
  parameter int NumLines = icache_pkg::DEFAULT_LINES,
  parameter int IdxW     = $clog2(NumLines)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_req_i,
  input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                          inval_i,
  input  logic                          key_ready_i,
  output logic                          fetch_valid_o,
  output logic [icache_pkg::DATA_W-1:0] fetch_rdata_o,
  output logic                          fetch_err_o,
  output logic [icache_pkg::ADDR_W-1:0] fetch_addr_o,
  output logic                          busy_o,
  icache_ram_if.user                    tag_ram,
  icache_ram_if.user                    data_ram,
  output logic                          miss_o,
  output logic [icache_pkg::ADDR_W-1:0] miss_addr_o,
  input  logic                          fill_done_i,
  input  logic                          fill_write_i,
  input  logic [icache_pkg::DATA_W-1:0] fill_data_i,
  input  logic                          fill_err_i,
  input  logic [IdxW-1:0]               fill_idx_i,
  input  icache_pkg::tag_entry_t        fill_tag_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_COMPARE,
    ST_WAIT,
    ST_CLEAR
  } state_e;

  state_e                        state_q;
  logic [NumLines-1:0]           valid_q;
  logic [IdxW-1:0]               clr_cnt_q;
  logic                          inval_pend_q;
  logic                          fetch_valid_q;
  logic [icache_pkg::ADDR_W-1:0] addr_q;
  logic [icache_pkg::DATA_W-1:0] rdata_q;
  logic                          err_q;
  logic [icache_pkg::ADDR_W-1:0] tag_bits;
  icache_pkg::tag_entry_t        addr_tag;
  logic [IdxW-1:0]               idx;
  logic                          accept;
  logic                          hit;

  assign idx          = addr_q[IdxW+1:2];
  assign tag_bits     = addr_q >> (IdxW + 2);
  assign addr_tag.tag = tag_bits[icache_pkg::TAG_W-1:0];

  // Busy also covers the result cycle and any outstanding rekey
  assign busy_o = (state_q != ST_IDLE) || fetch_valid_q || inval_pend_q || !key_ready_i;
  assign accept = (state_q == ST_IDLE) && fetch_req_i && !busy_o;
  assign hit    = valid_q[idx] && (tag_ram.rdata == addr_tag);

  // RAM port mux; refill only writes while this side sits in ST_WAIT
  assign tag_ram.req    = (state_q == ST_READ) || fill_write_i;
  assign tag_ram.write  = fill_write_i;
  assign tag_ram.addr   = fill_write_i ? fill_idx_i : idx;
  assign tag_ram.wdata  = fill_tag_i;
  assign data_ram.req   = (state_q == ST_READ) || fill_write_i;
  assign data_ram.write = fill_write_i;
  assign data_ram.addr  = fill_write_i ? fill_idx_i : idx;
  assign data_ram.wdata = fill_data_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= ST_IDLE;
      valid_q       <= '0;
      clr_cnt_q     <= '0;
      inval_pend_q  <= 1'b0;
      fetch_valid_q <= 1'b0;
    end else begin
      fetch_valid_q <= 1'b0;
      // Invalidate during a fetch waits for the fetch to finish
      if (inval_i) begin
        inval_pend_q <= 1'b1;
      end
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= ST_READ;
          end else if (inval_i || inval_pend_q) begin
            state_q      <= ST_CLEAR;
            clr_cnt_q    <= '0;
            inval_pend_q <= 1'b0;
          end
        end
        ST_READ: state_q <= ST_COMPARE;
        ST_COMPARE: begin
          if (hit) begin
            fetch_valid_q <= 1'b1;
            state_q       <= ST_IDLE;
          end else begin
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (fill_done_i) begin
            fetch_valid_q <= 1'b1;
            state_q       <= ST_IDLE;
            // Error responses never become valid lines
            if (fill_write_i) begin
              valid_q[idx] <= 1'b1;
            end
          end
        end
        ST_CLEAR: begin
          valid_q[clr_cnt_q] <= 1'b0;
          clr_cnt_q          <= clr_cnt_q + 1'b1;
          if (clr_cnt_q == IdxW'(NumLines - 1)) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= fetch_addr_i;
    end
    if (state_q == ST_COMPARE && hit) begin
      rdata_q <= data_ram.rdata;
      err_q   <= 1'b0;
    end
    if (state_q == ST_WAIT && fill_done_i) begin
      rdata_q <= fill_data_i;
      err_q   <= fill_err_i;
    end
  end

  // Miss request is a single pulse out of the compare cycle
  assign miss_o      = (state_q == ST_COMPARE) && !hit;
  assign miss_addr_o = addr_q;

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_rdata_o = rdata_q;
  assign fetch_err_o   = err_q;
  assign fetch_addr_o  = addr_q;

endmodule

//--- icache_key_ctrl.sv
/*
 * Scrambling key control
 * Holds the active key and fetches a fresh one after each invalidate
 */

`timescale 1ns/1ps

module icache_key_ctrl #(
  parameter logic [icache_pkg::KEY_W-1:0] KeyInit = 64'h5a3c_96e1_0f87_d24b
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         inval_i,
  input  logic                         key_valid_i,
  input  logic [icache_pkg::KEY_W-1:0] key_i,
  output logic                         key_req_o,
  output logic [icache_pkg::KEY_W-1:0] key_o,
  output logic                         key_ready_o
);

  logic                         req_q;
  logic [icache_pkg::KEY_W-1:0] key_q;

  // Request level rises after the invalidate and drops with the key
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (req_q) begin
      if (key_valid_i) begin
        req_q <= 1'b0;
      end
    end else if (inval_i) begin
      req_q <= 1'b1;
    end
  end

  // Reset key is fixed so the cache is usable straight out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      key_q <= KeyInit;
    end else if (req_q && key_valid_i) begin
      key_q <= key_i;
    end
  end

  assign key_req_o   = req_q;
  assign key_o       = key_q;
  assign key_ready_o = !req_q;

endmodule

//--- icache_scr_ram.sv
/*
 * Scrambled single-port RAM
 * Payloads are XORed with a key-derived keystream on write and on read
 */

`timescale 1ns/1ps

module icache_scr_ram #(
  parameter int  Depth     = icache_pkg::DEFAULT_LINES,
  parameter type payload_t = logic [icache_pkg::DATA_W-1:0]
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [icache_pkg::KEY_W-1:0] key_i,
  icache_ram_if.ram                    ram
);

  localparam int PW    = $bits(payload_t);
  localparam int AddrW = $clog2(Depth);

  logic [PW-1:0]    mem [Depth];
  logic [PW-1:0]    rd_raw_q;
  logic [AddrW-1:0] rd_idx_q;

  // Key rotated left by 5 bits per index, low bits kept
  function automatic logic [PW-1:0] keystream(
    input logic [icache_pkg::KEY_W-1:0] key,
    input int unsigned                  idx
  );
    logic [icache_pkg::KEY_W-1:0] rot;
    int unsigned                  sh;
    sh  = (idx * 5) % icache_pkg::KEY_W;
    rot = (key << sh) | (key >> (icache_pkg::KEY_W - sh));
    return rot[PW-1:0];
  endfunction

  always_ff @(posedge clk) begin
    if (ram.req) begin
      if (ram.write) begin
        mem[ram.addr] <= ram.wdata ^ keystream(key_i, int'(ram.addr));
      end else begin
        rd_raw_q <= mem[ram.addr];
      end
    end
  end

  // Index of the last read, needed to rebuild its keystream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_idx_q <= '0;
    end else if (ram.req && !ram.write) begin
      rd_idx_q <= ram.addr;
    end
  end

  // Descrambled with the key in use now, so stale lines decode to garbage
  assign ram.rdata = payload_t'(rd_raw_q ^ keystream(key_i, int'(rd_idx_q)));

endmodule

//--- icache_ram_if.sv
/*
 * Cache RAM port
 * Single-port request bundle between a RAM user and a scrambled RAM
 */

`timescale 1ns/1ps

interface icache_ram_if #(
  parameter int  IdxW      = 4,
  parameter type payload_t = logic [31:0]
) ();

  logic            req;
  logic            write;
  logic [IdxW-1:0] addr;
  payload_t        wdata;
  // Valid one cycle after a read request
  payload_t        rdata;

  modport user (
    output req,
    output write,
    output addr,
    output wdata,
    input  rdata
  );

  modport ram (
    input  req,
    input  write,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- icache_pkg.sv
/*
 * Instruction cache shared definitions
 * Geometry, address field widths and the tag entry stored in the tag RAM
 */

package icache_pkg;

  // Fetch address and instruction word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Scrambling key width
  localparam int KEY_W = 64;

  // Default cache depth, one 32-bit word per line
  localparam int DEFAULT_LINES = 16;
  localparam int DEFAULT_IDX_W = $clog2(DEFAULT_LINES);

  // Tag is everything above the index and the byte offset
  localparam int TAG_W = ADDR_W - 2 - DEFAULT_IDX_W;

  // Address layout of a fetch
  //   [1:0]             byte offset, ignored
  //   [IdxW+1:2]        line index
  //   [ADDR_W-1:IdxW+2] tag
  // A deeper cache leaves the upper tag bits at zero
  typedef struct packed {
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

endpackage
